// ==== filelist.f ====
common/core_pkg.sv
common/pipe_if.sv
core/decode_stage.sv
core/reg_file.sv
core/execute_stage.sv
core/result_stage.sv
src/la_core_top.sv
bench/clock_gen.sv
bench/core_checker.sv
bench/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run core_tb with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module core_tb -f filelist.f \
    --Mdir "$build_dir" -o core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/core_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== bench/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    // instructions per test
    localparam int n_load  = 62;
    localparam int n_rr    = 64;
    localparam int n_imm   = 48;
    localparam int n_zero  = 16;
    localparam int n_mix   = 64;
    localparam int n_total = n_load + n_rr + n_imm + n_zero + n_mix;
    localparam int unsigned cycle_limit = 2 * n_total + 200;

    // expected commit bundle
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      inst;
        logic [reg_idx_w-1:0] rd;
        logic                 wen;
        logic [xlen-1:0]      data;
        logic                 chk_data;
    } commit_t;

    logic                 clk;
    logic                 reset;
    logic                 inst_valid;
    logic                 inst_ready;
    logic [xlen-1:0]      inst;
    logic [xlen-1:0]      inst_pc;
    logic                 commit_valid;
    logic                 commit_ready;
    logic [xlen-1:0]      commit_pc;
    logic [xlen-1:0]      commit_inst;
    logic                 commit_wen;
    logic [reg_idx_w-1:0] commit_rd;
    logic [xlen-1:0]      commit_data;

    integer          seed = 32'h03e0_d048;
    int unsigned     errors = 0;
    int unsigned     commits = 0;
    int unsigned     cycles = 0;
    logic            random_ready;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] stim_q [$];
    commit_t         expect_q [$];
    // architectural register state
    logic [xlen-1:0] gold_regs [0:reg_count-1];

    clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    la_core_top uut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    function automatic logic [31:0] rnd_word();
        return $random(seed);
    endfunction

    // r1..r7, small set so dependencies are frequent
    function automatic logic [4:0] rnd_reg();
        return 5'(1 + rnd_word() % 7);
    endfunction

    function automatic logic [4:0] rnd_any_reg();
        return 5'(1 + rnd_word() % 31);
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [19:0] imm, input logic [4:0] rd);
        return {op_lu12i_w, imm, rd};
    endfunction

    function automatic logic [16:0] rr_op(input int sel);
        case (sel)
            0:       return op_add_w;
            1:       return op_sub_w;
            2:       return op_slt;
            3:       return op_and;
            4:       return op_or;
            default: return op_xor;
        endcase
    endfunction

    function automatic logic [31:0] rand_imm_inst(input logic [4:0] rd, input logic [4:0] rj);
        int          sel;
        logic [11:0] imm12;
        sel   = int'(rnd_word() % 5);
        imm12 = 12'(rnd_word());
        case (sel)
            0:       return enc_2ri12(op_addi_w, rd, rj, imm12);
            1:       return enc_2ri12(op_andi, rd, rj, imm12);
            2:       return enc_2ri12(op_ori, rd, rj, imm12);
            3:       return enc_2ri12(op_xori, rd, rj, imm12);
            default: return enc_1ri20(20'(rnd_word()), rd);
        endcase
    endfunction

    // add.d slot or a 0xf prefix, neither is executed
    function automatic logic [31:0] unknown_inst();
        logic [31:0] r;
        r = rnd_word();
        if (r[31])
            return {4'hf, r[27:0]};
        return {17'h00021, r[14:0]};
    endfunction

    // reference semantics of the executed subset
    task automatic model_exec(input logic [31:0] word, output logic known,
                              output logic [31:0] res);
        inst_u       view;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        view  = word;
        a     = gold_regs[view.fmt_3r.rj];
        b     = gold_regs[view.fmt_3r.rk];
        simm  = 32'($signed(view.fmt_2ri12.imm12));
        zimm  = 32'(view.fmt_2ri12.imm12);
        known = 1'b1;
        res   = 32'h0;
        if (view.fmt_1ri20.opcode == op_lu12i_w)
            res = {view.fmt_1ri20.imm20, 12'h000};
        else if (view.fmt_2ri12.opcode == op_addi_w)
            res = a + simm;
        else if (view.fmt_2ri12.opcode == op_andi)
            res = a & zimm;
        else if (view.fmt_2ri12.opcode == op_ori)
            res = a | zimm;
        else if (view.fmt_2ri12.opcode == op_xori)
            res = a ^ zimm;
        else if (view.fmt_3r.opcode == op_add_w)
            res = a + b;
        else if (view.fmt_3r.opcode == op_sub_w)
            res = a - b;
        else if (view.fmt_3r.opcode == op_slt)
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (view.fmt_3r.opcode == op_and)
            res = a & b;
        else if (view.fmt_3r.opcode == op_or)
            res = a | b;
        else if (view.fmt_3r.opcode == op_xor)
            res = a ^ b;
        else
            known = 1'b0;
    endtask

    // golden model step, in program order
    task automatic accept_inst(input logic [31:0] word, input logic [31:0] pc);
        commit_t     item;
        logic        known;
        logic [31:0] res;
        inst_u       view;
        view = word;
        model_exec(word, known, res);
        item.pc       = pc;
        item.inst     = word;
        item.rd       = view.fmt_3r.rd;
        item.wen      = known && (view.fmt_3r.rd != 5'd0);
        item.data     = res;
        item.chk_data = known;
        if (item.wen)
            gold_regs[item.rd] = res;
        expect_q.push_back(item);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("error: %s got %h expected %h", sig, got, want);
    endtask

    task automatic check_commit();
        commit_t head;
        commits++;
        assert (expect_q.size() != 0) else begin
            errors++;
            $display("commit at pc %h with no instruction outstanding", commit_pc);
        end
        if (expect_q.size() != 0) begin
            head = expect_q.pop_front();
            assert (commit_pc == head.pc)
                else report_mismatch("commit_pc", commit_pc, head.pc);
            assert (commit_inst == head.inst)
                else report_mismatch("commit_inst", commit_inst, head.inst);
            assert (commit_wen == head.wen)
                else report_mismatch("commit_wen", 32'(commit_wen), 32'(head.wen));
            assert (commit_rd == head.rd)
                else report_mismatch("commit_rd", 32'(commit_rd), 32'(head.rd));
            // unknown encodings carry no defined data
            if (head.chk_data) begin
                assert (commit_data == head.data)
                    else report_mismatch("commit_data", commit_data, head.data);
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r            = rnd_word();
        inst_valid   = (stim_q.size() != 0);
        inst         = (stim_q.size() != 0) ? stim_q[0] : 32'h0;
        inst_pc      = next_pc;
        commit_ready = random_ready ? r[0] : 1'b1;
    endtask

    // handshakes sampled mid-cycle, inputs move 2 ns after the edge
    task automatic run_cycle();
        logic took;
        @(negedge clk);
        took = inst_valid && inst_ready;
        if (took) begin
            accept_inst(stim_q[0], inst_pc);
            void'(stim_q.pop_front());
            next_pc = next_pc + 32'd4;
        end
        if (commit_valid && commit_ready)
            check_commit();
        @(posedge clk);
        #2;
        drive_inputs();
    endtask

    task automatic run_test(input string name, input logic rand_ready);
        int unsigned err0;
        int unsigned n0;
        err0         = errors;
        n0           = commits;
        random_ready = rand_ready;
        drive_inputs();
        while (stim_q.size() != 0 || expect_q.size() != 0)
            run_cycle();
        random_ready = 1'b0;
        $display("test %s: %0d commits, %0d errors", name, commits - n0, errors - err0);
    endtask

    // random 32-bit value into every register
    task automatic fill_load();
        logic [4:0] r;
        for (int i = 1; i < reg_count; i++) begin
            r = 5'(i);
            stim_q.push_back(enc_1ri20(20'(rnd_word()), r));
            stim_q.push_back(enc_2ri12(op_ori, r, r, 12'(rnd_word())));
        end
    endtask

    task automatic fill_reg_reg();
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [4:0] prev;
        logic [4:0] prev2;
        prev  = 5'd1;
        prev2 = 5'd2;
        for (int i = 0; i < n_rr; i++) begin
            rd = rnd_reg();
            // i-1 comes from execute, i-2 from result
            rj = (i % 2 == 0) ? prev : rnd_reg();
            rk = (i % 3 == 0) ? prev2 : rnd_reg();
            stim_q.push_back(enc_3r(rr_op(int'(rnd_word() % 6)), rd, rj, rk));
            prev2 = prev;
            prev  = rd;
        end
    endtask

    task automatic fill_imm();
        logic [4:0] rd;
        logic [4:0] prev;
        prev = 5'd3;
        for (int i = 0; i < n_imm; i++) begin
            rd = rnd_any_reg();
            stim_q.push_back(rand_imm_inst(rd, (i % 2 == 0) ? prev : rnd_any_reg()));
            prev = rd;
        end
    endtask

    // r0 targets and unknown ops, then reads of r0
    task automatic fill_zero();
        logic [31:0] word;
        for (int i = 0; i < n_zero; i++) begin
            case (i % 4)
                0:       word = enc_3r(rr_op(int'(rnd_word() % 6)), 5'd0, rnd_reg(), rnd_reg());
                1:       word = unknown_inst();
                2:       word = enc_2ri12(op_addi_w, rnd_any_reg(), 5'd0, 12'(rnd_word()));
                default: word = enc_3r(op_or, rnd_any_reg(), 5'd0, rnd_reg());
            endcase
            stim_q.push_back(word);
        end
    endtask

    task automatic fill_mix();
        logic [4:0] rd;
        logic [4:0] prev;
        prev = 5'd4;
        for (int i = 0; i < n_mix; i++) begin
            rd = rnd_reg();
            if (i % 2 == 0)
                stim_q.push_back(enc_3r(rr_op(int'(rnd_word() % 6)), rd, prev, rnd_reg()));
            else
                stim_q.push_back(rand_imm_inst(rd, prev));
            prev = rd;
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int unsigned total_errors;
        inst_valid   = 1'b0;
        inst         = 32'h0;
        inst_pc      = 32'h0;
        commit_ready = 1'b1;
        random_ready = 1'b0;
        next_pc      = 32'h1c00_0000;
        for (int r = 0; r < reg_count; r++)
            gold_regs[r] = 32'h0;
        @(negedge reset);
        fill_load();
        run_test("load", 1'b0);
        fill_reg_reg();
        run_test("reg_reg", 1'b0);
        fill_imm();
        run_test("immediate", 1'b0);
        fill_zero();
        run_test("r0_unknown", 1'b0);
        fill_mix();
        run_test("backpressure", 1'b1);
        total_errors = errors + uut.u_checker.fail_count;
        $display("summary: 5 tests, %0d commits, %0d errors", commits, total_errors);
        if (total_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_checker (
    input logic                           clk,
    input logic                           reset,
    input logic                           inst_valid,
    input logic                           inst_ready,
    input logic [core_pkg::xlen-1:0]      inst_pc,
    input logic                           commit_valid,
    input logic                           commit_ready,
    input logic [core_pkg::xlen-1:0]      commit_pc,
    input logic [core_pkg::xlen-1:0]      commit_inst,
    input logic                           commit_wen,
    input logic [core_pkg::reg_idx_w-1:0] commit_rd,
    input logic [core_pkg::xlen-1:0]      commit_data
);
    import core_pkg::*;

    // count of failed assertions
    int unsigned fail_count = 0;

    // pipeline empty and accepting right after reset
    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> !commit_valid && inst_ready)
        else begin
            $error("pipeline not empty and accepting after reset");
            fail_count++;
        end

    // stalled commit bundle must hold still
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        $past(commit_valid && !commit_ready) |->
            commit_valid && commit_pc == $past(commit_pc)
            && commit_inst == $past(commit_inst) && commit_wen == $past(commit_wen)
            && commit_rd == $past(commit_rd) && commit_data == $past(commit_data))
        else begin
            $error("commit bundle changed while stalled");
            fail_count++;
        end

    // three stages, one cycle each, when nothing pushes back
    three_cycle_latency: assert property (@(posedge clk) disable iff (reset)
        $past(inst_valid && inst_ready, 3) && $past(commit_ready, 1)
            && $past(commit_ready, 2) && $past(commit_ready, 3) |->
            commit_valid && commit_pc == $past(inst_pc, 3))
        else begin
            $error("accepted instruction did not reach commit three cycles later");
            fail_count++;
        end

    // every operand is bypassed, so no stall without back-pressure
    no_hazard_stall: assert property (@(posedge clk) disable iff (reset)
        commit_ready |-> inst_ready)
        else begin
            $error("input stalled while commit side was ready");
            fail_count++;
        end

endmodule

bind la_core_top core_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .inst_pc      (inst_pc),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
);

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    localparam int half_period_ns = 20;
    localparam int reset_cycles   = 16;

    // 40 ns free-running clock
    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // reset released just after the 16th rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/la_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module la_core_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           inst_valid,
    output logic                           inst_ready,
    input  logic [core_pkg::xlen-1:0]      inst,
    input  logic [core_pkg::xlen-1:0]      inst_pc,
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [core_pkg::xlen-1:0]      commit_pc,
    output logic [core_pkg::xlen-1:0]      commit_inst,
    output logic                           commit_wen,
    output logic [core_pkg::reg_idx_w-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]      commit_data
);
    import core_pkg::*;

    // register file ports
    logic [reg_idx_w-1:0] rd_index_a;
    logic [reg_idx_w-1:0] rd_index_b;
    logic [xlen-1:0]      rd_data_a;
    logic [xlen-1:0]      rd_data_b;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_index;
    logic [xlen-1:0]      wr_data;

    // bypass from later stages
    logic                 exe_fwd_valid;
    logic [reg_idx_w-1:0] exe_fwd_rd;
    logic [xlen-1:0]      exe_fwd_data;
    logic                 res_fwd_valid;
    logic [reg_idx_w-1:0] res_fwd_rd;
    logic [xlen-1:0]      res_fwd_data;

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    decode_stage u_decode (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .rd_index_a    (rd_index_a),
        .rd_index_b    (rd_index_b),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .exe_fwd_valid (exe_fwd_valid),
        .exe_fwd_rd    (exe_fwd_rd),
        .exe_fwd_data  (exe_fwd_data),
        .res_fwd_valid (res_fwd_valid),
        .res_fwd_rd    (res_fwd_rd),
        .res_fwd_data  (res_fwd_data),
        .down          (dec_exe.decode_side)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_data    (wr_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset         (reset),
        .up            (dec_exe.exe_side),
        .down          (exe_res.exe_side),
        .exe_fwd_valid (exe_fwd_valid),
        .exe_fwd_rd    (exe_fwd_rd),
        .exe_fwd_data  (exe_fwd_data)
    );

    // retire point, commit bundle out
    result_stage u_result (
        .clk           (clk),
        .reset         (reset),
        .up            (exe_res.res_side),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit_pc     (commit_pc),
        .commit_inst   (commit_inst),
        .commit_wen    (commit_wen),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .res_fwd_valid (res_fwd_valid),
        .res_fwd_rd    (res_fwd_rd),
        .res_fwd_data  (res_fwd_data)
    );

endmodule

`default_nettype wire

// ==== core/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  logic                           clk,
    input  logic                           reset,
    exe_res_if.res_side                    up,
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [core_pkg::xlen-1:0]      commit_pc,
    output logic [core_pkg::xlen-1:0]      commit_inst,
    output logic                           commit_wen,
    output logic [core_pkg::reg_idx_w-1:0] commit_rd,
    output logic [core_pkg::xlen-1:0]      commit_data,
    output logic                           wr_en,
    output logic [core_pkg::reg_idx_w-1:0] wr_index,
    output logic [core_pkg::xlen-1:0]      wr_data,
    output logic                           res_fwd_valid,
    output logic [core_pkg::reg_idx_w-1:0] res_fwd_rd,
    output logic [core_pkg::xlen-1:0]      res_fwd_data
);
    import core_pkg::*;

    logic                 valid_q;
    logic [xlen-1:0]      pc_q;
    logic [xlen-1:0]      inst_q;
    logic [xlen-1:0]      result_q;
    logic [reg_idx_w-1:0] rd_q;
    logic                 wen_q;

    // held item stays put while commit_ready is low
    assign up.ready = !valid_q || commit_ready;

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else if (up.ready)
            valid_q <= up.valid;
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            pc_q     <= up.pc;
            inst_q   <= up.inst;
            result_q <= up.result;
            rd_q     <= up.rd;
            wen_q    <= up.wen;
        end
    end

    assign commit_valid = valid_q;
    assign commit_pc    = pc_q;
    assign commit_inst  = inst_q;
    assign commit_wen   = wen_q;
    assign commit_rd    = rd_q;
    assign commit_data  = result_q;

    // register write only on the commit transfer
    assign wr_en    = valid_q && commit_ready && wen_q;
    assign wr_index = rd_q;
    assign wr_data  = result_q;

    assign res_fwd_valid = valid_q && wen_q;
    assign res_fwd_rd    = rd_q;
    assign res_fwd_data  = result_q;

endmodule

`default_nettype wire

// ==== core/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                           clk,
    input  logic                           reset,
    dec_exe_if.exe_side                    up,
    exe_res_if.exe_side                    down,
    output logic                           exe_fwd_valid,
    output logic [core_pkg::reg_idx_w-1:0] exe_fwd_rd,
    output logic [core_pkg::xlen-1:0]      exe_fwd_data
);
    import core_pkg::*;

    logic                 valid_q;
    logic [xlen-1:0]      pc_q;
    logic [xlen-1:0]      inst_q;
    alu_op_t              alu_op_q;
    logic [xlen-1:0]      src_a_q;
    logic [xlen-1:0]      src_b_q;
    logic [reg_idx_w-1:0] rd_q;
    logic                 wen_q;
    logic [xlen-1:0]      result;

    assign up.ready = !valid_q || down.ready;

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else if (up.ready)
            valid_q <= up.valid;
    end

    // operand register
    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            pc_q     <= up.pc;
            inst_q   <= up.inst;
            alu_op_q <= up.alu_op;
            src_a_q  <= up.src_a;
            src_b_q  <= up.src_b;
            rd_q     <= up.rd;
            wen_q    <= up.wen;
        end
    end

    always_comb begin
        case (alu_op_q)
            alu_add:    result = src_a_q + src_b_q;
            alu_sub:    result = src_a_q - src_b_q;
            // signed compare, 1 or 0
            alu_slt:    result = {31'b0, $signed(src_a_q) < $signed(src_b_q)};
            alu_and:    result = src_a_q & src_b_q;
            alu_or:     result = src_a_q | src_b_q;
            alu_xor:    result = src_a_q ^ src_b_q;
            // lu12i.w, immediate already shifted
            alu_pass_b: result = src_b_q;
            default:    result = '0;
        endcase
    end

    assign down.valid  = valid_q;
    assign down.pc     = pc_q;
    assign down.inst   = inst_q;
    assign down.result = result;
    assign down.rd     = rd_q;
    assign down.wen    = wen_q;

    // forward to decode, qualified here
    assign exe_fwd_valid = valid_q && wen_q;
    assign exe_fwd_rd    = rd_q;
    assign exe_fwd_data  = result;

endmodule

`default_nettype wire

// ==== core/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [core_pkg::reg_idx_w-1:0] rd_index_a,
    input  logic [core_pkg::reg_idx_w-1:0] rd_index_b,
    output logic [core_pkg::xlen-1:0]      rd_data_a,
    output logic [core_pkg::xlen-1:0]      rd_data_b,
    input  logic                           wr_en,
    input  logic [core_pkg::reg_idx_w-1:0] wr_index,
    input  logic [core_pkg::xlen-1:0]      wr_data
);
    import core_pkg::*;

    // r0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_index != '0) begin
            regs[wr_index] <= wr_data;
        end
    end

    // asynchronous reads, r0 reads zero
    assign rd_data_a = (rd_index_a == '0) ? '0 : regs[rd_index_a];
    assign rd_data_b = (rd_index_b == '0) ? '0 : regs[rd_index_b];

endmodule

`default_nettype wire

// ==== core/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             inst_valid,
    output logic                             inst_ready,
    input  core_pkg::inst_u                  inst,
    input  logic [core_pkg::xlen-1:0]        inst_pc,
    output logic [core_pkg::reg_idx_w-1:0]   rd_index_a,
    output logic [core_pkg::reg_idx_w-1:0]   rd_index_b,
    input  logic [core_pkg::xlen-1:0]        rd_data_a,
    input  logic [core_pkg::xlen-1:0]        rd_data_b,
    input  logic                             exe_fwd_valid,
    input  logic [core_pkg::reg_idx_w-1:0]   exe_fwd_rd,
    input  logic [core_pkg::xlen-1:0]        exe_fwd_data,
    input  logic                             res_fwd_valid,
    input  logic [core_pkg::reg_idx_w-1:0]   res_fwd_rd,
    input  logic [core_pkg::xlen-1:0]        res_fwd_data,
    dec_exe_if.decode_side                   down
);
    import core_pkg::*;

    logic            valid_q;
    inst_u           inst_q;
    logic [xlen-1:0] pc_q;

    alu_op_t         alu_op;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            known;
    logic [xlen-1:0] opnd_a;
    logic [xlen-1:0] opnd_b;

    // youngest producer wins: execute, then result, then register file
    function automatic logic [xlen-1:0] bypass(
        input logic [reg_idx_w-1:0] idx,
        input logic [xlen-1:0]      rf_val
    );
        logic [xlen-1:0] val;
        if (idx == '0)
            val = '0;
        else if (exe_fwd_valid && exe_fwd_rd == idx)
            val = exe_fwd_data;
        else if (res_fwd_valid && res_fwd_rd == idx)
            val = res_fwd_data;
        else
            val = rf_val;
        return val;
    endfunction

    // empty, or our item leaves this cycle
    assign inst_ready = !valid_q || down.ready;

    always_ff @(posedge clk) begin
        if (reset)
            valid_q <= 1'b0;
        else if (inst_ready)
            valid_q <= inst_valid;
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            inst_q <= inst;
            pc_q   <= inst_pc;
        end
    end

    // rj and rk sit at the same bits in 3R and 2RI12
    assign rd_index_a = inst_q.fmt_3r.rj;
    assign rd_index_b = inst_q.fmt_3r.rk;

    // format decode
    always_comb begin
        alu_op  = alu_add;
        imm     = '0;
        use_imm = 1'b0;
        known   = 1'b1;
        if (inst_q.fmt_1ri20.opcode == op_lu12i_w) begin
            alu_op  = alu_pass_b;
            imm     = {inst_q.fmt_1ri20.imm20, 12'b0};
            use_imm = 1'b1;
        end else begin
            case (inst_q.fmt_2ri12.opcode)
                op_addi_w: begin
                    // sign-extended immediate
                    alu_op  = alu_add;
                    imm     = {{20{inst_q.fmt_2ri12.imm12[11]}}, inst_q.fmt_2ri12.imm12};
                    use_imm = 1'b1;
                end
                op_andi: begin
                    alu_op  = alu_and;
                    imm     = {20'b0, inst_q.fmt_2ri12.imm12};
                    use_imm = 1'b1;
                end
                op_ori: begin
                    alu_op  = alu_or;
                    imm     = {20'b0, inst_q.fmt_2ri12.imm12};
                    use_imm = 1'b1;
                end
                op_xori: begin
                    alu_op  = alu_xor;
                    imm     = {20'b0, inst_q.fmt_2ri12.imm12};
                    use_imm = 1'b1;
                end
                default: begin
                    // not an immediate op, try 3R
                    case (inst_q.fmt_3r.opcode)
                        op_add_w: alu_op = alu_add;
                        op_sub_w: alu_op = alu_sub;
                        op_slt:   alu_op = alu_slt;
                        op_and:   alu_op = alu_and;
                        op_or:    alu_op = alu_or;
                        op_xor:   alu_op = alu_xor;
                        default:  known  = 1'b0;
                    endcase
                end
            endcase
        end
    end

    // operand read through the bypass
    always_comb begin
        opnd_a = bypass(rd_index_a, rd_data_a);
        opnd_b = bypass(rd_index_b, rd_data_b);
    end

    assign down.valid  = valid_q;
    assign down.pc     = pc_q;
    assign down.inst   = inst_q;
    assign down.alu_op = alu_op;
    assign down.src_a  = opnd_a;
    assign down.src_b  = use_imm ? imm : opnd_b;
    assign down.rd     = inst_q.fmt_3r.rd;
    // unknown op or r0 target retires without a write
    assign down.wen    = known && (inst_q.fmt_3r.rd != '0);

endmodule

`default_nettype wire

// ==== common/pipe_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// decode to execute hop
interface dec_exe_if;
    import core_pkg::*;

    logic                 valid;
    logic                 ready;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      inst;
    alu_op_t              alu_op;
    // operands already resolved through the bypass
    logic [xlen-1:0]      src_a;
    logic [xlen-1:0]      src_b;
    logic [reg_idx_w-1:0] rd;
    logic                 wen;

    modport decode_side (
        output valid, pc, inst, alu_op, src_a, src_b, rd, wen,
        input  ready
    );

    modport exe_side (
        input  valid, pc, inst, alu_op, src_a, src_b, rd, wen,
        output ready
    );
endinterface

// execute to result hop
interface exe_res_if;
    import core_pkg::*;

    logic                 valid;
    logic                 ready;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      inst;
    logic [xlen-1:0]      result;
    logic [reg_idx_w-1:0] rd;
    logic                 wen;

    modport exe_side (
        output valid, pc, inst, result, rd, wen,
        input  ready
    );

    modport res_side (
        input  valid, pc, inst, result, rd, wen,
        output ready
    );
endinterface

`default_nettype wire

// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // datapath and register file geometry
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    // 3R major opcodes, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;

    // 1RI20 opcode, inst[31:25]
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    // alu operation, carried from decode to execute
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // register-register format
    typedef struct packed {
        logic [16:0]          opcode;
        logic [reg_idx_w-1:0] rk;
        logic [reg_idx_w-1:0] rj;
        logic [reg_idx_w-1:0] rd;
    } fmt_3r_t;

    // register plus 12-bit immediate
    typedef struct packed {
        logic [9:0]           opcode;
        logic [11:0]          imm12;
        logic [reg_idx_w-1:0] rj;
        logic [reg_idx_w-1:0] rd;
    } fmt_2ri12_t;

    // 20-bit immediate, lu12i.w
    typedef struct packed {
        logic [6:0]           opcode;
        logic [19:0]          imm20;
        logic [reg_idx_w-1:0] rd;
    } fmt_1ri20_t;

    // one instruction word, three views
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
    } inst_u;

endpackage

`default_nettype wire
